// ==== hw/tcip_consts.svh ====
/*
  tcip constants: bus widths, credit count, region bases,
  CLINT register offsets and the accepted access size
*/
`ifndef TCIP_CONSTS_SVH
`define TCIP_CONSTS_SVH

// --------------------
// widths
// --------------------
`define TCIP_ADDR_W 32
`define TCIP_DATA_W 32
// offset handed to the targets, low address half
`define TCIP_OFS_W 16

// buffer depth, also the credits per bus after reset
`define TCIP_CREDITS 4

// --------------------
// address map
// --------------------
// upper address half of each region
`define TCIP_CLINT_BASE 16'hE000
`define TCIP_HAD_BASE 16'hE001

// clint word offsets
`define TCIP_MSIP_OFS 16'h0000
`define TCIP_MTIMECMP_LO_OFS 16'h4000
`define TCIP_MTIMECMP_HI_OFS 16'h4004
// mtime words, read only
`define TCIP_MTIME_LO_OFS 16'hBFF8
`define TCIP_MTIME_HI_OFS 16'hBFFC

// size codes
`define TCIP_SIZE_WORD 2'b10

`endif

// ==== hw/tcip_pkg.sv ====
/*
  tcip types: data and instruction bus requests, response,
  target request and the clint interrupt bundle
*/
`include "tcip_consts.svh"

package tcip_pkg;

  // --------------------
  // bus side
  // --------------------

  // data bus request from the bmu
  typedef struct packed {
    logic [`TCIP_ADDR_W-1:0] addr;
    logic [`TCIP_DATA_W-1:0] wdata;
    // access size code, only word reaches the clint
    logic [1:0]              size;
    logic                    write;
    logic                    supv_mode;
    // bmu side protection results
    logic                    acc_deny;
    logic                    chk_fail;
  } dbus_req_t;

  // instruction bus request, always answered with an error
  typedef struct packed {
    logic [`TCIP_ADDR_W-1:0] addr;
    logic                    write;
    logic                    acc_deny;
  } ibus_req_t;

  // response, same shape on both buses
  typedef struct packed {
    logic [`TCIP_DATA_W-1:0] data;
    logic                    err;
  } tcip_rsp_t;

  // --------------------
  // target side
  // --------------------

  // request to clint or had
  typedef struct packed {
    logic [`TCIP_OFS_W-1:0]  ofs;
    logic                    write;
    logic [`TCIP_DATA_W-1:0] wdata;
  } tgt_req_t;

  // interrupts to the core
  typedef struct packed {
    logic ms;
    logic mt;
    logic me;
  } clint_int_t;

endpackage

// ==== hw/tcip_fifo.sv ====
/*
  request buffer with a generic payload type,
  circular storage, pointers and an entry count,
  one credit pulse per pop
*/
`timescale 1ns/10ps
`include "tcip_consts.svh"

module tcip_fifo #(
  parameter type payload_t = logic,
  parameter int  depth     = `TCIP_CREDITS
) (
  input  logic     forever_cpuclk,
  input  logic     reset,
  input  logic     push,
  input  payload_t push_data,
  input  logic     pop,
  output payload_t head,
  output logic     not_empty,
  output logic     credit_ret
);

  localparam int ptr_w = (depth > 1) ? $clog2(depth) : 1;
  localparam int cnt_w = $clog2(depth + 1);
  localparam logic [ptr_w-1:0] last_ptr = ptr_w'(depth - 1);

  payload_t         mem [depth];
  logic [ptr_w-1:0] wr_ptr;
  logic [ptr_w-1:0] rd_ptr;
  logic [cnt_w-1:0] count;
  logic             pop_ok;

  // a pop of an empty buffer is dropped
  assign pop_ok    = pop & not_empty;
  assign not_empty = (count != '0);
  assign head      = mem[rd_ptr];

  // --------------------
  // pointers and count
  // --------------------
  always_ff @(posedge forever_cpuclk) begin
    if (reset) begin
      wr_ptr     <= '0;
      rd_ptr     <= '0;
      count      <= '0;
      credit_ret <= 1'b0;
    end else begin
      // pointers wrap at depth, not only at powers of two
      if (push) begin
        wr_ptr <= (wr_ptr == last_ptr) ? '0 : wr_ptr + 1'b1;
      end
      if (pop_ok) begin
        rd_ptr <= (rd_ptr == last_ptr) ? '0 : rd_ptr + 1'b1;
      end
      case ({push, pop_ok})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
      // credit goes back the cycle after the entry leaves
      credit_ret <= pop_ok;
    end
  end

  // storage
  always_ff @(posedge forever_cpuclk) begin
    if (push) begin
      mem[wr_ptr] <= push_data;
    end
  end

endmodule

// ==== hw/tcip_dbus_ctrl.sv ====
/*
  data bus controller: region decode, access checks,
  one operation at a time to clint or had, response register
*/
`timescale 1ns/10ps
`include "tcip_consts.svh"

module tcip_dbus_ctrl (
  input  logic                    forever_cpuclk,
  input  logic                    reset,
  input  tcip_pkg::dbus_req_t     head,
  input  logic                    not_empty,
  output logic                    pop,
  output tcip_pkg::tgt_req_t      tgt_req,
  output logic                    clint_req_vld,
  input  logic [`TCIP_DATA_W-1:0] clint_rdata,
  output logic                    had_sel,
  input  logic                    had_cmplt,
  input  logic [`TCIP_DATA_W-1:0] had_rdata,
  output logic                    dbus_rsp_vld,
  output tcip_pkg::tcip_rsp_t     dbus_rsp
);

  typedef enum logic [1:0] {
    st_idle,
    st_issue,
    st_had_wait,
    st_rsp
  } state_t;

  state_t              state;
  tcip_pkg::dbus_req_t op;
  logic                is_clint;
  logic                is_had;
  logic                acc_err;
  logic                rsp_load;

  // take a new request only when nothing is in service
  assign pop = (state == st_idle) & not_empty;

  // operation register, loaded at the pop
  always_ff @(posedge forever_cpuclk) begin
    if (pop) begin
      op <= head;
    end
  end

  // --------------------
  // decode and checks
  // --------------------
  assign is_clint = (op.addr[`TCIP_ADDR_W-1:`TCIP_OFS_W] == `TCIP_CLINT_BASE);
  assign is_had   = (op.addr[`TCIP_ADDR_W-1:`TCIP_OFS_W] == `TCIP_HAD_BASE);

  // bmu flags, unmapped region, clint size and privilege
  assign acc_err = op.acc_deny | op.chk_fail | ~(is_clint | is_had)
                 | (is_clint & (op.size != `TCIP_SIZE_WORD))
                 | (is_clint & op.write & ~op.supv_mode);

  // shared target request, the select tells who takes it
  assign tgt_req = '{
    ofs:   op.addr[`TCIP_OFS_W-1:0],
    write: op.write,
    wdata: op.wdata
  };

  // selects only in the issue cycle, never for a failed check
  assign clint_req_vld = (state == st_issue) & is_clint & ~acc_err;
  assign had_sel       = (state == st_issue) & is_had & ~acc_err;

  // --------------------
  // state machine
  // --------------------
  always_ff @(posedge forever_cpuclk) begin
    if (reset) begin
      state <= st_idle;
    end else begin
      case (state)
        st_idle: begin
          if (pop) begin
            state <= st_issue;
          end
        end
        st_issue: begin
          // clint and errors finish here, had may finish at once
          if (had_sel & ~had_cmplt) begin
            state <= st_had_wait;
          end else begin
            state <= st_rsp;
          end
        end
        st_had_wait: begin
          if (had_cmplt) begin
            state <= st_rsp;
          end
        end
        default: begin
          state <= st_idle;
        end
      endcase
    end
  end

  // --------------------
  // response
  // --------------------
  // clint data is there in the issue cycle, had data with cmplt
  assign rsp_load = (state == st_issue) | ((state == st_had_wait) & had_cmplt);

  always_ff @(posedge forever_cpuclk) begin
    if (rsp_load) begin
      dbus_rsp.err <= acc_err;
      if (acc_err) begin
        dbus_rsp.data <= '0;
      end else if (is_clint) begin
        dbus_rsp.data <= clint_rdata;
      end else begin
        dbus_rsp.data <= had_rdata;
      end
    end
  end

  // single cycle valid, no back-pressure on this side
  assign dbus_rsp_vld = (state == st_rsp);

endmodule

// ==== hw/tcip_clint.sv ====
/*
  clint registers: msip and 64 bit mtimecmp,
  mtime compare and the interrupt outputs
*/
`timescale 1ns/10ps
`include "tcip_consts.svh"

module tcip_clint (
  input  logic                    forever_cpuclk,
  input  logic                    reset,
  input  logic                    clint_req_vld,
  input  tcip_pkg::tgt_req_t      tgt_req,
  output logic [`TCIP_DATA_W-1:0] clint_rdata,
  input  logic [63:0]             mtime,
  input  logic                    sysio_me_int,
  output tcip_pkg::clint_int_t    clint_int
);

  logic        msip;
  logic [63:0] mtimecmp;
  logic        mt_int;
  logic        me_int;
  logic        wr_en;

  assign wr_en = clint_req_vld & tgt_req.write;

  // --------------------
  // register writes
  // --------------------
  always_ff @(posedge forever_cpuclk) begin
    if (reset) begin
      msip     <= 1'b0;
      // all ones keeps the timer quiet until software sets it
      mtimecmp <= '1;
    end else if (wr_en) begin
      case (tgt_req.ofs)
        `TCIP_MSIP_OFS: begin
          msip <= tgt_req.wdata[0];
        end
        `TCIP_MTIMECMP_LO_OFS: begin
          mtimecmp[31:0] <= tgt_req.wdata;
        end
        `TCIP_MTIMECMP_HI_OFS: begin
          mtimecmp[63:32] <= tgt_req.wdata;
        end
        // mtime and unknown offsets drop the write
        default: begin
          msip <= msip;
        end
      endcase
    end
  end

  // --------------------
  // read mux
  // --------------------
  // answered in the select cycle
  always_comb begin
    clint_rdata = '0;
    case (tgt_req.ofs)
      `TCIP_MSIP_OFS:        clint_rdata = {{(`TCIP_DATA_W-1){1'b0}}, msip};
      `TCIP_MTIMECMP_LO_OFS: clint_rdata = mtimecmp[31:0];
      `TCIP_MTIMECMP_HI_OFS: clint_rdata = mtimecmp[63:32];
      `TCIP_MTIME_LO_OFS:    clint_rdata = mtime[31:0];
      `TCIP_MTIME_HI_OFS:    clint_rdata = mtime[63:32];
      default:               clint_rdata = '0;
    endcase
  end

  // --------------------
  // interrupts
  // --------------------
  // timer compare and external line, registered once
  always_ff @(posedge forever_cpuclk) begin
    if (reset) begin
      mt_int <= 1'b0;
      me_int <= 1'b0;
    end else begin
      mt_int <= (mtime >= mtimecmp);
      me_int <= sysio_me_int;
    end
  end

  // software interrupt straight from the register
  assign clint_int = '{
    ms: msip,
    mt: mt_int,
    me: me_int
  };

endmodule

// ==== hw/tcip_ibus_err.sv ====
/*
  instruction bus stage, answers every buffered request
  with an access error
*/
`timescale 1ns/10ps

module tcip_ibus_err (
  input  logic                forever_cpuclk,
  input  logic                reset,
  input  logic                not_empty,
  output logic                pop,
  output logic                ibus_rsp_vld,
  output tcip_pkg::tcip_rsp_t ibus_rsp
);

  // nothing is mapped here, drain one entry per cycle
  assign pop = not_empty;

  // valid one cycle after the pop
  always_ff @(posedge forever_cpuclk) begin
    if (reset) begin
      ibus_rsp_vld <= 1'b0;
    end else begin
      ibus_rsp_vld <= pop;
    end
  end

  // error with zero data
  always_ff @(posedge forever_cpuclk) begin
    if (pop) begin
      ibus_rsp.data <= '0;
      ibus_rsp.err  <= 1'b1;
    end
  end

endmodule

// ==== hw/tcip_top.sv ====
/*
  tcip top: request buffers for both buses, data bus
  controller, clint and the instruction bus error stage
*/
`timescale 1ns/10ps
`include "tcip_consts.svh"

module tcip_top (
  input  logic                    forever_cpuclk,
  input  logic                    reset,
  // data bus
  input  logic                    dbus_req_vld,
  input  tcip_pkg::dbus_req_t     dbus_req,
  output logic                    dbus_credit_ret,
  output logic                    dbus_rsp_vld,
  output tcip_pkg::tcip_rsp_t     dbus_rsp,
  // instruction bus
  input  logic                    ibus_req_vld,
  input  tcip_pkg::ibus_req_t     ibus_req,
  output logic                    ibus_credit_ret,
  output logic                    ibus_rsp_vld,
  output tcip_pkg::tcip_rsp_t     ibus_rsp,
  // had port
  output logic                    had_sel,
  output tcip_pkg::tgt_req_t      had_req,
  input  logic                    had_cmplt,
  input  logic [`TCIP_DATA_W-1:0] had_rdata,
  // clint side
  input  logic [63:0]             mtime,
  input  logic                    sysio_me_int,
  output tcip_pkg::clint_int_t    clint_int
);

  tcip_pkg::dbus_req_t     dbus_head;
  logic                    dbus_not_empty;
  logic                    dbus_pop;
  logic                    ibus_not_empty;
  logic                    ibus_pop;
  tcip_pkg::tgt_req_t      tgt_req;
  logic                    clint_req_vld;
  logic [`TCIP_DATA_W-1:0] clint_rdata;

  // --------------------
  // data bus path
  // --------------------
  tcip_fifo #(
    .payload_t (tcip_pkg::dbus_req_t),
    .depth     (`TCIP_CREDITS)
  ) x_dbus_fifo (
    .forever_cpuclk (forever_cpuclk),
    .reset          (reset),
    .push           (dbus_req_vld),
    .push_data      (dbus_req),
    .pop            (dbus_pop),
    .head           (dbus_head),
    .not_empty      (dbus_not_empty),
    .credit_ret     (dbus_credit_ret)
  );

  tcip_dbus_ctrl x_dbus_ctrl (
    .forever_cpuclk (forever_cpuclk),
    .reset          (reset),
    .head           (dbus_head),
    .not_empty      (dbus_not_empty),
    .pop            (dbus_pop),
    .tgt_req        (tgt_req),
    .clint_req_vld  (clint_req_vld),
    .clint_rdata    (clint_rdata),
    .had_sel        (had_sel),
    .had_cmplt      (had_cmplt),
    .had_rdata      (had_rdata),
    .dbus_rsp_vld   (dbus_rsp_vld),
    .dbus_rsp       (dbus_rsp)
  );

  // had sees the same target request as the clint
  assign had_req = tgt_req;

  tcip_clint x_clint (
    .forever_cpuclk (forever_cpuclk),
    .reset          (reset),
    .clint_req_vld  (clint_req_vld),
    .tgt_req        (tgt_req),
    .clint_rdata    (clint_rdata),
    .mtime          (mtime),
    .sysio_me_int   (sysio_me_int),
    .clint_int      (clint_int)
  );

  // --------------------
  // instruction bus path
  // --------------------
  // payload is never looked at, every fetch here is an error
  tcip_fifo #(
    .payload_t (tcip_pkg::ibus_req_t),
    .depth     (`TCIP_CREDITS)
  ) x_ibus_fifo (
    .forever_cpuclk (forever_cpuclk),
    .reset          (reset),
    .push           (ibus_req_vld),
    .push_data      (ibus_req),
    .pop            (ibus_pop),
    .head           (),
    .not_empty      (ibus_not_empty),
    .credit_ret     (ibus_credit_ret)
  );

  tcip_ibus_err x_ibus_err (
    .forever_cpuclk (forever_cpuclk),
    .reset          (reset),
    .not_empty      (ibus_not_empty),
    .pop            (ibus_pop),
    .ibus_rsp_vld   (ibus_rsp_vld),
    .ibus_rsp       (ibus_rsp)
  );

endmodule

// ==== bench/tcip_chk.sv ====
/*
  bound protocol checks on tcip_top for credit accounting, outstanding
  limit, had select pulse, responses and quiet outputs in reset
*/
`timescale 1ns/10ps
`include "tcip_consts.svh"

module tcip_chk (
  input logic forever_cpuclk,
  input logic reset,
  input logic dbus_req_vld,
  input logic dbus_credit_ret,
  input logic dbus_rsp_vld,
  input logic ibus_req_vld,
  input logic ibus_credit_ret,
  input logic ibus_rsp_vld,
  input logic had_sel
);

  // accepted, returned and answered per bus
  logic [15:0] d_acc;
  logic [15:0] d_ret;
  logic [15:0] d_rsp;
  logic [15:0] i_acc;
  logic [15:0] i_ret;
  logic [15:0] i_rsp;
  logic        chk_failed = 1'b0;

  always_ff @(posedge forever_cpuclk) begin
    if (reset) begin
      d_acc <= '0;
      d_ret <= '0;
      d_rsp <= '0;
      i_acc <= '0;
      i_ret <= '0;
      i_rsp <= '0;
    end else begin
      d_acc <= d_acc + 16'(dbus_req_vld);
      d_ret <= d_ret + 16'(dbus_credit_ret);
      d_rsp <= d_rsp + 16'(dbus_rsp_vld);
      i_acc <= i_acc + 16'(ibus_req_vld);
      i_ret <= i_ret + 16'(ibus_credit_ret);
      i_rsp <= i_rsp + 16'(ibus_rsp_vld);
    end
  end

  // --------------------
  // credits
  // --------------------
  // a credit only for an entry that was taken
  credit_back: assert property (@(posedge forever_cpuclk) disable iff (reset)
    (!dbus_credit_ret || (d_ret < d_acc)) && (!ibus_credit_ret || (i_ret < i_acc)))
  else begin
    $error("credit returned without an accepted request");
    chk_failed = 1'b1;
  end

  // at most a full buffer plus the one in service
  credit_limit: assert property (@(posedge forever_cpuclk) disable iff (reset)
    ((d_acc - d_rsp) <= (`TCIP_CREDITS + 1))
    && ((i_acc - i_rsp) <= (`TCIP_CREDITS + 1)))
  else begin
    $error("more requests outstanding than the buffer can hold");
    chk_failed = 1'b1;
  end

  // --------------------
  // handshakes
  // --------------------
  had_pulse: assert property (@(posedge forever_cpuclk) disable iff (reset)
    had_sel |=> !had_sel)
  else begin
    $error("had_sel held longer than one cycle");
    chk_failed = 1'b1;
  end

  rsp_owed: assert property (@(posedge forever_cpuclk) disable iff (reset)
    (!dbus_rsp_vld || (d_rsp < d_acc)) && (!ibus_rsp_vld || (i_rsp < i_acc)))
  else begin
    $error("response without an outstanding request");
    chk_failed = 1'b1;
  end

  // outputs quiet the cycle after reset is seen
  reset_quiet: assert property (@(posedge forever_cpuclk)
    reset |=> !(dbus_rsp_vld || ibus_rsp_vld || had_sel || dbus_credit_ret || ibus_credit_ret))
  else begin
    $error("output active after reset");
    chk_failed = 1'b1;
  end

endmodule

bind tcip_top tcip_chk chk0 (
  .forever_cpuclk  (forever_cpuclk),
  .reset           (reset),
  .dbus_req_vld    (dbus_req_vld),
  .dbus_credit_ret (dbus_credit_ret),
  .dbus_rsp_vld    (dbus_rsp_vld),
  .ibus_req_vld    (ibus_req_vld),
  .ibus_credit_ret (ibus_credit_ret),
  .ibus_rsp_vld    (ibus_rsp_vld),
  .had_sel         (had_sel)
);

// ==== bench/tcip_tb.sv ====
/*
  tcip testbench with clock, reset, lfsr driven requests on both buses,
  had model, reference model with expected response queues, run limit
*/
`timescale 1ns/10ps
`include "tcip_consts.svh"

module tcip_tb;

  // limit is about six times the 650 cycles the tests take
  localparam int          max_cycles       = 4000;
  localparam int          had_stall_cycles = 24;
  localparam logic [63:0] mtime_idle       = 64'h0000_0002_1234_5678;

  // expected response and what to compare
  typedef struct packed {
    tcip_pkg::tcip_rsp_t rsp;
    logic                data_chk;
    logic                ms_chk;
    logic                ms_val;
  } exp_rsp_t;

  logic                    forever_cpuclk;
  logic                    reset;
  logic                    dbus_req_vld;
  tcip_pkg::dbus_req_t     dbus_req;
  logic                    dbus_credit_ret;
  logic                    dbus_rsp_vld;
  tcip_pkg::tcip_rsp_t     dbus_rsp;
  logic                    ibus_req_vld;
  tcip_pkg::ibus_req_t     ibus_req;
  logic                    ibus_credit_ret;
  logic                    ibus_rsp_vld;
  tcip_pkg::tcip_rsp_t     ibus_rsp;
  logic                    had_sel;
  tcip_pkg::tgt_req_t      had_req;
  logic                    had_cmplt;
  logic [`TCIP_DATA_W-1:0] had_rdata;
  logic [63:0]             mtime;
  logic                    sysio_me_int;
  tcip_pkg::clint_int_t    clint_int;

  exp_rsp_t           dbus_exp[$];
  exp_rsp_t           ibus_exp[$];
  tcip_pkg::tgt_req_t had_exp[$];
  int                 dbus_credits;
  int                 ibus_credits;
  int                 cycles = 0;
  int                 had_wait;
  logic               had_busy;
  logic               had_stall;
  logic               timer_on;
  logic [31:0]        stim_lfsr;
  logic [31:0]        had_lfsr;
  // reference copies of the clint registers
  logic               msip_m;
  logic [63:0]        mtimecmp_m;
  logic [63:0]        mtime_prev;
  logic               me_prev;
  string              test_name;

  // port names match the top level
  tcip_top dut0 (.*);

  initial begin
    forever_cpuclk = 1'b0;
    forever begin
      #10 forever_cpuclk = ~forever_cpuclk;
    end
  end

  // --------------------
  // helpers
  // --------------------
  // fibonacci lfsr with taps 32 22 2 1
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  // one step per bit taken
  task automatic draw_bits(inout logic [31:0] st, input int n, output logic [31:0] v);
    v = '0;
    for (int i = 0; i < n; i++) begin
      st = lfsr_step(st);
      v  = {v[30:0], st[0]};
    end
  endtask

  task automatic abort_run();
    $display("Errors found");
    $fatal(1, "run stopped in test %s", test_name);
  endtask

  task automatic value_mismatch(input string what, input logic [63:0] expected,
                                input logic [63:0] actual);
    $display("Error: %s %s expected %h actual %h", test_name, what, expected, actual);
    abort_run();
  endtask

  task automatic protocol_problem(input string msg);
    $display("%s: %s", test_name, msg);
    abort_run();
  endtask

  // supervisor word access
  function automatic tcip_pkg::dbus_req_t make_req(input logic [15:0] base,
      input logic [15:0] ofs, input logic write, input logic [31:0] wdata);
    tcip_pkg::dbus_req_t r;
    r           = '0;
    r.addr      = {base, ofs};
    r.wdata     = wdata;
    r.size      = `TCIP_SIZE_WORD;
    r.write     = write;
    r.supv_mode = 1'b1;
    return r;
  endfunction

  // --------------------
  // reference model
  // --------------------
  task automatic predict_dbus(input tcip_pkg::dbus_req_t r);
    exp_rsp_t           e;
    tcip_pkg::tgt_req_t t;
    logic               clint;
    logic               had;
    logic               err;
    logic [15:0]        ofs;
    clint = (r.addr[31:16] == `TCIP_CLINT_BASE);
    had   = (r.addr[31:16] == `TCIP_HAD_BASE);
    ofs   = r.addr[15:0];
    err   = r.acc_deny | r.chk_fail | !(clint | had)
          | (clint & (r.size != `TCIP_SIZE_WORD)) | (clint & r.write & !r.supv_mode);
    e          = '0;
    e.rsp.err  = err;
    e.data_chk = 1'b1;
    if (err) begin
      e.rsp.data = '0;
    end else if (had) begin
      // had model answers with the inverted write data
      e.rsp.data = ~r.wdata;
      t = '{ofs: ofs, write: r.write, wdata: r.wdata};
      had_exp.push_back(t);
    end else if (r.write) begin
      // write response data carries no meaning
      e.data_chk = 1'b0;
      case (ofs)
        `TCIP_MSIP_OFS: begin
          msip_m   = r.wdata[0];
          e.ms_chk = 1'b1;
          e.ms_val = r.wdata[0];
        end
        `TCIP_MTIMECMP_LO_OFS: mtimecmp_m[31:0]  = r.wdata;
        `TCIP_MTIMECMP_HI_OFS: mtimecmp_m[63:32] = r.wdata;
        default: e.ms_chk = 1'b0;
      endcase
    end else begin
      case (ofs)
        `TCIP_MSIP_OFS:        e.rsp.data = {31'b0, msip_m};
        `TCIP_MTIMECMP_LO_OFS: e.rsp.data = mtimecmp_m[31:0];
        `TCIP_MTIMECMP_HI_OFS: e.rsp.data = mtimecmp_m[63:32];
        `TCIP_MTIME_LO_OFS:    e.rsp.data = mtime_idle[31:0];
        `TCIP_MTIME_HI_OFS:    e.rsp.data = mtime_idle[63:32];
        default:               e.rsp.data = '0;
      endcase
    end
    dbus_exp.push_back(e);
  endtask

  // --------------------
  // request drivers
  // --------------------
  task automatic send_dbus(input tcip_pkg::dbus_req_t r);
    @(posedge forever_cpuclk);
    while (dbus_credits == 0) begin
      dbus_req_vld <= 1'b0;
      @(posedge forever_cpuclk);
    end
    dbus_req_vld <= 1'b1;
    dbus_req     <= r;
    dbus_credits--;
    predict_dbus(r);
  endtask

  task automatic send_ibus(input tcip_pkg::ibus_req_t q);
    exp_rsp_t e;
    @(posedge forever_cpuclk);
    while (ibus_credits == 0) begin
      ibus_req_vld <= 1'b0;
      @(posedge forever_cpuclk);
    end
    ibus_req_vld <= 1'b1;
    ibus_req     <= q;
    ibus_credits--;
    // nothing is fetchable here
    e            = '0;
    e.rsp.err    = 1'b1;
    ibus_exp.push_back(e);
  endtask

  task automatic idle_buses();
    @(posedge forever_cpuclk);
    dbus_req_vld <= 1'b0;
    ibus_req_vld <= 1'b0;
  endtask

  // wait until every response is seen and every credit is home
  task automatic wait_drained();
    idle_buses();
    while (dbus_exp.size() != 0 || ibus_exp.size() != 0
           || dbus_credits != `TCIP_CREDITS || ibus_credits != `TCIP_CREDITS) begin
      @(posedge forever_cpuclk);
    end
  endtask

  task automatic rand_dbus(output tcip_pkg::dbus_req_t r);
    logic [31:0] v;
    r = '0;
    draw_bits(stim_lfsr, 2, v);
    case (v[1:0])
      2'd0:    r.addr[31:16] = `TCIP_CLINT_BASE;
      2'd3:    r.addr[31:16] = 16'hE002;
      default: r.addr[31:16] = `TCIP_HAD_BASE;
    endcase
    draw_bits(stim_lfsr, 3, v);
    case (v[2:0])
      3'd0:    r.addr[15:0] = `TCIP_MSIP_OFS;
      3'd1:    r.addr[15:0] = `TCIP_MTIMECMP_LO_OFS;
      3'd2:    r.addr[15:0] = `TCIP_MTIMECMP_HI_OFS;
      3'd3:    r.addr[15:0] = `TCIP_MTIME_LO_OFS;
      3'd4:    r.addr[15:0] = `TCIP_MTIME_HI_OFS;
      default: r.addr[15:0] = 16'h0100;
    endcase
    draw_bits(stim_lfsr, 32, v);
    r.wdata = v;
    draw_bits(stim_lfsr, 10, v);
    // mostly clean supervisor word accesses
    r.write     = v[0];
    r.supv_mode = v[1] | v[2];
    r.size      = (v[5:3] == 3'd0) ? 2'b01 : `TCIP_SIZE_WORD;
    r.acc_deny  = (v[8:6] == 3'b111);
    r.chk_fail  = v[9] & v[8] & ~v[7];
  endtask

  // --------------------
  // had model
  // --------------------
  always @(posedge forever_cpuclk) begin
    tcip_pkg::tgt_req_t t;
    logic [31:0]        v;
    if (reset) begin
      had_cmplt <= 1'b0;
      had_busy  = 1'b0;
    end else begin
      had_cmplt <= 1'b0;
      if (had_sel) begin
        if (had_exp.size() == 0) begin
          protocol_problem("had_sel with no forwarded request pending");
        end else begin
          t = had_exp.pop_front();
          assert (had_req == t) else value_mismatch("had_req", t, had_req);
        end
        // own lfsr stream keeps delays stable when stimulus changes
        draw_bits(had_lfsr, 3, v);
        had_wait  = had_stall ? had_stall_cycles : int'(v[2:0]);
        had_busy  = 1'b1;
        had_rdata <= ~had_req.wdata;
      end
      if (had_busy) begin
        if (had_wait == 0) begin
          had_cmplt <= 1'b1;
          had_busy  = 1'b0;
        end else begin
          had_wait--;
        end
      end
    end
  end

  // --------------------
  // monitors sample mid cycle
  // --------------------
  task automatic check_dbus_rsp();
    exp_rsp_t e;
    if (dbus_exp.size() == 0) begin
      protocol_problem("data bus response with no request waiting");
    end else begin
      e = dbus_exp.pop_front();
      assert (dbus_rsp.err == e.rsp.err) else value_mismatch("dbus err", e.rsp.err, dbus_rsp.err);
      if (e.data_chk) begin
        assert (dbus_rsp.data == e.rsp.data)
        else value_mismatch("dbus data", e.rsp.data, dbus_rsp.data);
      end
      if (e.ms_chk) begin
        assert (clint_int.ms == e.ms_val) else value_mismatch("ms", e.ms_val, clint_int.ms);
      end
    end
  endtask

  task automatic check_ibus_rsp();
    exp_rsp_t e;
    if (ibus_exp.size() == 0) begin
      protocol_problem("instruction bus response with no request waiting");
    end else begin
      e = ibus_exp.pop_front();
      assert (ibus_rsp == e.rsp) else value_mismatch("ibus rsp", e.rsp, ibus_rsp);
    end
  endtask

  always @(negedge forever_cpuclk) begin
    if (!reset) begin
      if (dbus_credit_ret) begin
        dbus_credits++;
      end
      if (ibus_credit_ret) begin
        ibus_credits++;
      end
      assert (dbus_credits <= `TCIP_CREDITS && ibus_credits <= `TCIP_CREDITS)
      else protocol_problem("more credits came back than were spent");
      if (dbus_rsp_vld) begin
        check_dbus_rsp();
      end
      if (ibus_rsp_vld) begin
        check_ibus_rsp();
      end
      if (dut0.chk0.chk_failed) begin
        protocol_problem("a bound protocol assertion failed");
      end
    end
  end

  // mt and me follow last cycle's inputs
  always @(negedge forever_cpuclk) begin
    if (timer_on) begin
      assert (clint_int.mt == (mtime_prev >= mtimecmp_m))
      else value_mismatch("mt", mtime_prev >= mtimecmp_m, clint_int.mt);
      assert (clint_int.me == me_prev) else value_mismatch("me", me_prev, clint_int.me);
    end
    mtime_prev = mtime;
    me_prev    = sysio_me_int;
  end

  always @(posedge forever_cpuclk) begin
    cycles++;
    if (cycles >= max_cycles) begin
      protocol_problem("run did not finish within the cycle limit");
    end
  end

  // --------------------
  // test sequence
  // --------------------
  initial begin
    tcip_pkg::dbus_req_t r;
    tcip_pkg::ibus_req_t q;
    logic [31:0]         v;
    reset        = 1'b1;
    dbus_req_vld = 1'b0;
    dbus_req     = '0;
    ibus_req_vld = 1'b0;
    ibus_req     = '0;
    had_cmplt    = 1'b0;
    had_rdata    = '0;
    mtime        = mtime_idle;
    sysio_me_int = 1'b0;
    dbus_credits = `TCIP_CREDITS;
    ibus_credits = `TCIP_CREDITS;
    stim_lfsr    = 32'h8c29;
    had_lfsr     = 32'h8c29;
    had_stall    = 1'b0;
    had_busy     = 1'b0;
    had_wait     = 0;
    timer_on     = 1'b0;
    msip_m       = 1'b0;
    mtimecmp_m   = '1;
    mtime_prev   = mtime_idle;
    me_prev      = 1'b0;
    test_name    = "reset";
    repeat (16) @(posedge forever_cpuclk);
    reset <= 1'b0;

    test_name = "msip";
    send_dbus(make_req(`TCIP_CLINT_BASE, `TCIP_MSIP_OFS, 1'b1, 32'h1));
    send_dbus(make_req(`TCIP_CLINT_BASE, `TCIP_MSIP_OFS, 1'b0, 32'h0));
    send_dbus(make_req(`TCIP_CLINT_BASE, `TCIP_MSIP_OFS, 1'b1, 32'hFFFF_FFF0));
    send_dbus(make_req(`TCIP_CLINT_BASE, `TCIP_MSIP_OFS, 1'b0, 32'h0));
    send_dbus(make_req(`TCIP_CLINT_BASE, `TCIP_MSIP_OFS, 1'b1, 32'h1));
    wait_drained();

    // each bad access leaves msip and mtimecmp as they were
    test_name = "errors";
    send_dbus(make_req(`TCIP_CLINT_BASE, `TCIP_MTIMECMP_LO_OFS, 1'b1, 32'h1234_0000));
    r = make_req(16'hE002, `TCIP_MSIP_OFS, 1'b1, 32'h0);
    send_dbus(r);
    r.write = 1'b0;
    send_dbus(r);
    r = make_req(`TCIP_CLINT_BASE, `TCIP_MSIP_OFS, 1'b1, 32'h0);
    r.acc_deny = 1'b1;
    send_dbus(r);
    r = make_req(`TCIP_CLINT_BASE, `TCIP_MSIP_OFS, 1'b1, 32'h0);
    r.chk_fail = 1'b1;
    send_dbus(r);
    r = make_req(`TCIP_CLINT_BASE, `TCIP_MSIP_OFS, 1'b1, 32'h0);
    r.size = 2'b01;
    send_dbus(r);
    r = make_req(`TCIP_CLINT_BASE, `TCIP_MTIMECMP_LO_OFS, 1'b1, 32'h0);
    r.supv_mode = 1'b0;
    send_dbus(r);
    send_dbus(make_req(`TCIP_CLINT_BASE, `TCIP_MSIP_OFS, 1'b0, 32'h0));
    send_dbus(make_req(`TCIP_CLINT_BASE, `TCIP_MTIMECMP_LO_OFS, 1'b0, 32'h0));
    send_dbus(make_req(`TCIP_CLINT_BASE, `TCIP_MTIMECMP_HI_OFS, 1'b0, 32'h0));
    wait_drained();

    test_name = "random";
    repeat (40) begin
      rand_dbus(r);
      send_dbus(r);
    end
    wait_drained();

    // slow had fills the buffer until credits run out
    test_name = "had burst";
    had_stall = 1'b1;
    for (int i = 0; i < 8; i++) begin
      draw_bits(stim_lfsr, 32, v);
      send_dbus(make_req(`TCIP_HAD_BASE, 16'(i * 4), v[0], v));
    end
    wait_drained();
    had_stall = 1'b0;

    test_name = "ibus";
    repeat (12) begin
      draw_bits(stim_lfsr, 32, v);
      q.addr = v;
      draw_bits(stim_lfsr, 2, v);
      q.write    = v[0];
      q.acc_deny = v[1];
      send_ibus(q);
    end
    wait_drained();

    // mtime walks across mtimecmp
    test_name = "timer";
    send_dbus(make_req(`TCIP_CLINT_BASE, `TCIP_MTIMECMP_LO_OFS, 1'b1, mtime_idle[31:0] + 32'd8));
    send_dbus(make_req(`TCIP_CLINT_BASE, `TCIP_MTIMECMP_HI_OFS, 1'b1, mtime_idle[63:32]));
    wait_drained();
    @(posedge forever_cpuclk);
    timer_on = 1'b1;
    repeat (16) begin
      @(posedge forever_cpuclk);
      draw_bits(stim_lfsr, 1, v);
      mtime        <= mtime + 64'd1;
      sysio_me_int <= v[0];
    end
    repeat (2) @(posedge forever_cpuclk);
    timer_on = 1'b0;

    test_name = "end";
    repeat (4) @(posedge forever_cpuclk);
    if (dut0.chk0.chk_failed) begin
      abort_run();
    end else begin
      $display("No errors");
      $finish;
    end
  end

endmodule

// ==== build.f ====
+incdir+hw
hw/tcip_pkg.sv
hw/tcip_fifo.sv
hw/tcip_dbus_ctrl.sv
hw/tcip_clint.sv
hw/tcip_ibus_err.sv
hw/tcip_top.sv
bench/tcip_chk.sv
bench/tcip_tb.sv
